//--- design/uart_pkg.sv
package uart_pkg;

    // Link timing with 16x oversampling
    localparam int CLOCKS_PER_TICK = 2;
    localparam int TICKS_PER_BIT   = 16;
    localparam int DATA_BITS       = 8;

    // Buffering on each side of the sequencer
    localparam int FIFO_DEPTH = 8;

    typedef logic [DATA_BITS-1:0]                uart_byte_t;
    typedef logic [$clog2(DATA_BITS)-1:0]        bit_index_t;
    typedef logic [$clog2(TICKS_PER_BIT)-1:0]    tick_count_t;
    typedef logic [$clog2(CLOCKS_PER_TICK)-1:0]  clock_div_t;
    typedef logic [$clog2(FIFO_DEPTH)-1:0]       fifo_addr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0]     fifo_count_t;

endpackage

//--- design/alu_pkg.sv
package alu_pkg;

    localparam int OPCODE_WIDTH = 6;

    // Only the low three bits of B set the shift distance
    localparam int SHIFT_WIDTH = 3;
    localparam uart_pkg::uart_byte_t UNDEFINED_RESULT = '0;

    typedef logic [SHIFT_WIDTH-1:0] shift_amount_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        SRL = 6'h02,
        SRA = 6'h03,
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        XOR = 6'h26,
        NOR = 6'h27
    } opcode_t;

    typedef struct packed {
        opcode_t              opcode;
        uart_pkg::uart_byte_t operand_a;
        uart_pkg::uart_byte_t operand_b;
    } alu_operands_t;

    typedef enum logic [1:0] {GET_OPCODE, GET_A, GET_B, ISSUE} sequencer_state_t;

endpackage

//--- design/baud_tick_gen.sv
module baud_tick_gen (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);

    uart_pkg::clock_div_t div_count;
    logic                 tick;

    // One tick every CLOCKS_PER_TICK clocks, shared by rx and tx
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else begin
            if (div_count == uart_pkg::clock_div_t'(uart_pkg::CLOCKS_PER_TICK - 1)) begin
                div_count <= '0;
                tick      <= 1'b1;
            end else begin
                div_count <= div_count + 1'b1;
                tick      <= 1'b0;
            end
        end
    end

    assign o_tick = tick;

endmodule

//--- design/uart_rx.sv
module uart_rx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_rx,
    output uart_pkg::uart_byte_t o_data,
    output logic                 o_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t             state;
    logic [1:0]            rx_sync;
    uart_pkg::tick_count_t tick_count;
    uart_pkg::bit_index_t  bit_index;
    uart_pkg::uart_byte_t  shift_reg;
    logic                  valid;

    logic rx_bit;
    logic half_bit;
    logic full_bit;

    // Line idles high, so the synchronizer resets to 1
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    assign rx_bit   = rx_sync[1];
    assign half_bit = (tick_count == uart_pkg::tick_count_t'(uart_pkg::TICKS_PER_BIT / 2 - 1));
    assign full_bit = (tick_count == uart_pkg::tick_count_t'(uart_pkg::TICKS_PER_BIT - 1));

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state      <= RX_IDLE;
            tick_count <= '0;
            bit_index  <= '0;
            valid      <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_bit) begin
                        state      <= RX_START;
                        tick_count <= '0;
                    end
                end
                RX_START: begin
                    if (i_tick) begin
                        // Glitch shorter than half a bit goes back to idle
                        if (half_bit) begin
                            state      <= rx_bit ? RX_IDLE : RX_DATA;
                            tick_count <= '0;
                            bit_index  <= '0;
                        end else begin
                            tick_count <= tick_count + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_tick) begin
                        if (full_bit) begin
                            tick_count <= '0;
                            if (bit_index == uart_pkg::bit_index_t'(uart_pkg::DATA_BITS - 1)) begin
                                state <= RX_STOP;
                            end else begin
                                bit_index <= bit_index + 1'b1;
                            end
                        end else begin
                            tick_count <= tick_count + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (i_tick) begin
                        if (full_bit) begin
                            state <= RX_IDLE;
                            valid <= rx_bit;  // bad stop bit drops the frame
                        end else begin
                            tick_count <= tick_count + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && i_tick && full_bit) begin
            shift_reg <= {rx_bit, shift_reg[uart_pkg::DATA_BITS-1:1]};
        end
    end

    assign o_data  = shift_reg;
    assign o_valid = valid;

    a_valid_single: assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |=> !o_valid);

endmodule

//--- design/byte_fifo.sv
module byte_fifo (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_wr,
    input  uart_pkg::uart_byte_t i_data,
    input  logic                 i_rd,
    output uart_pkg::uart_byte_t o_data,
    output logic                 o_empty,
    output logic                 o_full
);

    uart_pkg::uart_byte_t mem [uart_pkg::FIFO_DEPTH];
    uart_pkg::fifo_addr_t wr_ptr;
    uart_pkg::fifo_addr_t rd_ptr;
    uart_pkg::fifo_count_t count;

    logic do_wr;
    logic do_rd;

    assign o_empty = (count == '0);
    assign o_full  = (count == uart_pkg::fifo_count_t'(uart_pkg::FIFO_DEPTH));

    // Writes while full are dropped
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    always_ff @(posedge i_clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead head entry
    assign o_data = mem[rd_ptr];

    a_no_overflow: assert property (@(posedge i_clock) disable iff (i_reset) i_wr |-> !o_full)
        else $error("byte_fifo overflow, byte dropped");
    a_no_underflow: assert property (@(posedge i_clock) disable iff (i_reset) i_rd |-> !o_empty);

endmodule

//--- design/alu_core.sv
module alu_core (
    input  alu_pkg::alu_operands_t i_operands,
    output uart_pkg::uart_byte_t   o_result
);

    alu_pkg::shift_amount_t shift_amount;
    uart_pkg::uart_byte_t   a;
    uart_pkg::uart_byte_t   b;
    uart_pkg::uart_byte_t   result;

    assign a            = i_operands.operand_a;
    assign b            = i_operands.operand_b;
    assign shift_amount = b[alu_pkg::SHIFT_WIDTH-1:0];

    // Add and sub wrap modulo 256
    always_comb begin
        case (i_operands.opcode)
            alu_pkg::ADD: result = a + b;
            alu_pkg::SUB: result = a - b;
            alu_pkg::AND: result = a & b;
            alu_pkg::OR:  result = a | b;
            alu_pkg::XOR: result = a ^ b;
            alu_pkg::NOR: result = ~(a | b);
            alu_pkg::SRL: result = a >> shift_amount;
            // Sign bit of A fills from the left
            alu_pkg::SRA: result = uart_pkg::uart_byte_t'($signed(a) >>> shift_amount);
            default:      result = alu_pkg::UNDEFINED_RESULT;
        endcase
    end

    assign o_result = result;

endmodule

//--- design/alu_command_sequencer.sv
module alu_command_sequencer (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  uart_pkg::uart_byte_t    i_data,
    input  logic                    i_fifo_empty,
    input  logic                    i_fifo_full,
    input  uart_pkg::uart_byte_t    i_result,
    output logic                    o_rd,
    output logic                    o_wr,
    output uart_pkg::uart_byte_t    o_result,
    output alu_pkg::alu_operands_t  o_operands
);

    alu_pkg::sequencer_state_t state;
    alu_pkg::alu_operands_t    operands;

    //////////////////////////////
    // FIFO strobes
    //////////////////////////////

    // Pop the head as soon as a byte is waiting in any GET state
    assign o_rd = (state != alu_pkg::ISSUE) && !i_fifo_empty;

    // Hold in ISSUE while the tx FIFO is full
    assign o_wr = (state == alu_pkg::ISSUE) && !i_fifo_full;

    assign o_result   = i_result;
    assign o_operands = operands;

    //////////////////////////////
    // Command FSM
    //////////////////////////////
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state <= alu_pkg::GET_OPCODE;
        end else begin
            case (state)
                alu_pkg::GET_OPCODE: begin
                    if (o_rd) state <= alu_pkg::GET_A;
                end
                alu_pkg::GET_A: begin
                    if (o_rd) state <= alu_pkg::GET_B;
                end
                alu_pkg::GET_B: begin
                    if (o_rd) state <= alu_pkg::ISSUE;
                end
                alu_pkg::ISSUE: begin
                    if (o_wr) state <= alu_pkg::GET_OPCODE;
                end
                default: state <= alu_pkg::GET_OPCODE;
            endcase
        end
    end

    // Head byte captured in the same cycle as the read pulse
    always_ff @(posedge i_clock) begin
        if (o_rd) begin
            case (state)
                alu_pkg::GET_OPCODE: begin
                    // Upper two bits of the opcode byte are dropped here
                    operands.opcode <= alu_pkg::opcode_t'(i_data[alu_pkg::OPCODE_WIDTH-1:0]);
                end
                alu_pkg::GET_A: operands.operand_a <= i_data;
                alu_pkg::GET_B: operands.operand_b <= i_data;
                default: ;
            endcase
        end
    end

    // Show-ahead head holds a real byte whenever it is popped
    a_rd_has_data: assert property (@(posedge i_clock) disable iff (i_reset)
        o_rd |-> !$isunknown(i_data));

    // One write per command, then back to collecting
    a_wr_in_issue: assert property (@(posedge i_clock) disable iff (i_reset)
        o_wr |-> (state == alu_pkg::ISSUE) ##1 (state == alu_pkg::GET_OPCODE));

endmodule

//--- design/uart_tx.sv
module uart_tx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  logic                 i_fifo_empty,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_rd,
    output logic                 o_tx
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t             state;
    uart_pkg::tick_count_t tick_count;
    uart_pkg::bit_index_t  bit_index;
    uart_pkg::uart_byte_t  shift_reg;
    logic                  tx_bit;
    logic                  bit_done;

    assign o_rd     = (state == TX_IDLE) && !i_fifo_empty;
    assign bit_done = i_tick && (tick_count == uart_pkg::tick_count_t'(uart_pkg::TICKS_PER_BIT - 1));

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge i_clock or posedge i_reset) begin
        if (i_reset) begin
            state      <= TX_IDLE;
            tick_count <= '0;
            bit_index  <= '0;
            tx_bit     <= 1'b1;
        end else begin
            if (i_tick) tick_count <= tick_count + 1'b1;
            case (state)
                TX_IDLE: begin
                    // Start bit goes out the cycle after the read
                    if (o_rd) begin
                        state      <= TX_START;
                        tick_count <= '0;
                        tx_bit     <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state     <= TX_DATA;
                        bit_index <= '0;
                        tx_bit    <= shift_reg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_index == uart_pkg::bit_index_t'(uart_pkg::DATA_BITS - 1)) begin
                            state  <= TX_STOP;
                            tx_bit <= 1'b1;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            tx_bit    <= shift_reg[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte loaded on the read, shifted out LSB first
    always_ff @(posedge i_clock) begin
        if (o_rd) begin
            shift_reg <= i_data;
        end else if (state == TX_DATA && bit_done) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    assign o_tx = tx_bit;

endmodule

//--- design/uart_alu_top.sv
module uart_alu_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_rx,
    output logic o_tx
);

    logic                   tick;
    uart_pkg::uart_byte_t   rx_data;
    logic                   rx_valid;
    uart_pkg::uart_byte_t   rx_fifo_data;
    logic                   rx_fifo_empty;
    logic                   rx_fifo_rd;
    uart_pkg::uart_byte_t   seq_result;
    logic                   seq_wr;
    alu_pkg::alu_operands_t operands;
    uart_pkg::uart_byte_t   alu_result;
    uart_pkg::uart_byte_t   tx_fifo_data;
    logic                   tx_fifo_empty;
    logic                   tx_fifo_full;
    logic                   tx_fifo_rd;

    baud_tick_gen u_baud_tick_gen (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    //////////////////////////////
    // Receive path
    //////////////////////////////
    uart_rx u_uart_rx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_rx),
        .o_data  (rx_data),
        .o_valid (rx_valid)
    );

    // No flow control on the line, so rx full is left open
    byte_fifo u_rx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_wr    (rx_valid),
        .i_data  (rx_data),
        .i_rd    (rx_fifo_rd),
        .o_data  (rx_fifo_data),
        .o_empty (rx_fifo_empty),
        .o_full  ()
    );

    //////////////////////////////
    // Command and ALU
    //////////////////////////////
    alu_command_sequencer u_sequencer (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_data       (rx_fifo_data),
        .i_fifo_empty (rx_fifo_empty),
        .i_fifo_full  (tx_fifo_full),
        .i_result     (alu_result),
        .o_rd         (rx_fifo_rd),
        .o_wr         (seq_wr),
        .o_result     (seq_result),
        .o_operands   (operands)
    );

    alu_core u_alu_core (
        .i_operands (operands),
        .o_result   (alu_result)
    );

    //////////////////////////////
    // Transmit path
    //////////////////////////////
    byte_fifo u_tx_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_wr    (seq_wr),
        .i_data  (seq_result),
        .i_rd    (tx_fifo_rd),
        .o_data  (tx_fifo_data),
        .o_empty (tx_fifo_empty),
        .o_full  (tx_fifo_full)
    );

    uart_tx u_uart_tx (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_tick       (tick),
        .i_fifo_empty (tx_fifo_empty),
        .i_data       (tx_fifo_data),
        .o_rd         (tx_fifo_rd),
        .o_tx         (o_tx)
    );

endmodule

//--- test/tb_uart_alu.sv
module tb_uart_alu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    BIT_CLOCKS     = uart_pkg::CLOCKS_PER_TICK * uart_pkg::TICKS_PER_BIT;
    localparam int    FRAME_NS       = 10 * BIT_CLOCKS * 40;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    MAX_GAP_CLOCKS = 64;
    localparam string TRACE_FILE     = "test/uart_alu_trace.txt";

    logic i_clock;
    logic i_reset;
    logic i_rx;
    logic o_tx;

    uart_pkg::uart_byte_t opcode_q[$];
    uart_pkg::uart_byte_t a_q[$];
    uart_pkg::uart_byte_t b_q[$];
    uart_pkg::uart_byte_t expected_q[$];
    int                   spaced_q[$];
    uart_pkg::uart_byte_t received_q[$];

    int trace_count  = 0;
    int result_index = 0;
    int bytes_sent   = 0;
    bit trace_loaded = 1'b0;
    bit frame_active = 1'b0;

    uart_alu_top u_dut (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    always #20 i_clock = ~i_clock;

    task automatic abort_run(input string detail);
        $display("%s", detail);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    // Ends just after a rising edge, where inputs change
    task automatic wait_clocks(input int count);
        repeat (count) @(posedge i_clock);
        #DRIVE_DELAY;
    endtask

    //////////////////////////////
    // Serial driver
    //////////////////////////////
    task automatic send_byte(input uart_pkg::uart_byte_t value);
        logic [9:0] line_bits;
        line_bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            i_rx = line_bits[0];
            // Byte counts as sent once its stop bit is on the line
            if (i == 9) begin
                bytes_sent++;
            end
            line_bits = line_bits >> 1;
            wait_clocks(BIT_CLOCKS);
        end
    endtask

    task automatic idle_gap(input int spaced);
        int gap;
        gap = 0;
        if (spaced != 0) begin
            gap = $urandom_range(0, MAX_GAP_CLOCKS);
        end
        if (gap > 0) begin
            wait_clocks(gap);
        end
    endtask

    // Gaps also fall between the bytes of one command
    task automatic send_command(input int index);
        idle_gap(spaced_q[index]);
        send_byte(opcode_q[index]);
        idle_gap(spaced_q[index]);
        send_byte(a_q[index]);
        idle_gap(spaced_q[index]);
        send_byte(b_q[index]);
    endtask

    task automatic load_trace();
        int                   fd;
        int                   fields;
        int                   spaced;
        string                text;
        uart_pkg::uart_byte_t opcode;
        uart_pkg::uart_byte_t a;
        uart_pkg::uart_byte_t b;
        uart_pkg::uart_byte_t expected;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file");
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(text, "%h %h %h %h %d", opcode, a, b, expected, spaced);
            if (fields != 5) begin
                abort_run($sformatf("Trace line could not be read: %s", text));
            end
            opcode_q.push_back(opcode);
            a_q.push_back(a);
            b_q.push_back(b);
            expected_q.push_back(expected);
            spaced_q.push_back(spaced);
        end
        $fclose(fd);
        trace_count = opcode_q.size();
        if (trace_count == 0) begin
            abort_run("The trace file holds no commands");
        end
    endtask

    task automatic check_result(input uart_pkg::uart_byte_t actual);
        string test_name;
        assert (result_index < trace_count)
            else abort_run("An extra result frame arrived after the last command");
        test_name = $sformatf("command %0d op %02h", result_index + 1, opcode_q[result_index]);
        assert (actual === expected_q[result_index])
            else abort_run($sformatf("FAILED %s: expected %02h, actual %02h",
                                     test_name, expected_q[result_index], actual));
        result_index++;
    endtask

    //////////////////////////////
    // Serial monitor
    //////////////////////////////
    initial begin
        uart_pkg::uart_byte_t value;
        value = '0;
        forever begin
            @(negedge o_tx);
            frame_active = 1'b1;
            assert (bytes_sent >= 3)
                else abort_run("A frame started on o_tx before the first command was sent");
            // Sample on the falling clock, halfway into each bit
            repeat (BIT_CLOCKS / 2) @(negedge i_clock);
            assert (o_tx === 1'b0)
                else abort_run("Start bit on o_tx did not hold to its middle");
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLOCKS) @(negedge i_clock);
                value = {o_tx, value[7:1]};
            end
            repeat (BIT_CLOCKS) @(negedge i_clock);
            assert (o_tx === 1'b1)
                else abort_run("Stop bit on o_tx was low");
            received_q.push_back(value);
            check_result(value);
            frame_active = 1'b0;
        end
    end

    // Budget of six frame times per command
    initial begin
        wait (trace_loaded);
        #(trace_count * 6 * FRAME_NS + 100_000);
        abort_run($sformatf("Timeout: no result arrived for command %0d of %0d",
                            result_index + 1, trace_count));
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int seed_value;
        i_clock    = 1'b0;
        i_reset    = 1'b1;
        i_rx       = 1'b1;
        seed_value = $urandom(16441);
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(posedge i_clock);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        assert (o_tx === 1'b1)
            else abort_run("o_tx was not idle high after reset");
        for (int i = 0; i < trace_count; i++) begin
            send_command(i);
        end
        wait (result_index == trace_count);
        // Quiet line afterwards, so nothing extra was queued
        wait_clocks(20 * BIT_CLOCKS);
        if (!frame_active && received_q.size() == trace_count) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("An extra frame started on o_tx after the last result");
        end
    end

endmodule

//--- files.f
design/uart_pkg.sv
design/alu_pkg.sv
design/baud_tick_gen.sv
design/uart_rx.sv
design/byte_fifo.sv
design/alu_core.sv
design/alu_command_sequencer.sv
design/uart_tx.sv
design/uart_alu_top.sv
test/tb_uart_alu.sv

//--- Makefile
SIM := obj_dir/Vtb_uart_alu

.PHONY: all run clean

all: run

$(SIM): files.f $(shell cat files.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_uart_alu -f files.f

run: $(SIM)
	$(SIM) 2>&1 | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/uart_alu_trace.txt
# opcode a b expected spaced (hex bytes, then 1 for random idle gaps or 0 for back to back)
# opcodes with the upper two bits set are masked down to six bits by the DUT
20 12 34 46 1
20 F0 25 15 1
22 50 20 30 1
22 10 20 F0 1
24 CC AA 88 1
25 CC AA EE 1
26 CC AA 66 1
27 CC AA 11 1
02 F0 04 0F 1
02 81 0B 10 1
03 F0 04 FF 1
03 90 02 E4 1
03 70 03 0E 1
15 12 34 00 1
3F FF FF 00 1
E0 7F 01 80 1
A6 0F F0 FF 1
C2 80 07 01 1
62 00 01 FF 1
20 01 02 03 0
22 FF 0F F0 0
24 F0 3C 30 0
25 0F 30 3F 0
26 FF 55 AA 0
27 00 00 FF 0
02 FF 01 7F 0
03 80 07 FF 0
20 FF FF FE 0
22 00 FF 01 0
03 7F 09 3F 0
27 0F F0 00 1
26 5A 5A 00 1
00 00 00 00 1
